//--- list.f
logic/ring_pkg.sv
logic/readout_pkg.sv
logic/l1a_fifo.sv
logic/sample_ram.sv
logic/ring_addr_ctrl.sv
logic/readout_fsm.sv
logic/ringbuf.sv
tb/ringbuf_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the ring buffer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module ringbuf_tb -Mdir obj_dir -f list.f -o ringbuf_tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/ringbuf_tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SIMULATION PASSED" "$log"; then
	exit 0
fi
echo "Pass message not found in $log"
exit 1

//--- tb/ringbuf_tb.sv
`timescale 1ns/1ps

module ringbuf_tb
	import ring_pkg::*;
();

	typedef struct packed {
		int         trig; // Sample index at which the L1A fires
		l1a_cnt_t   cnt;
		match_cnt_t mcnt;
		logic       phase;
		logic       match;
		samp_max_t  smax;
		int         hold; // Cycles of evt_buf_afl_i high
	} row_t;

	typedef struct packed {
		int         row;
		int         start;
		l1a_cnt_t   l1a_cnt;
		match_cnt_t match_cnt;
		logic       phase;
		samp_max_t  smax;
	} hdr_t;

	localparam int n_rows_c     = 8;
	localparam int clk_period_c = 100;

	row_t tbl [n_rows_c] = '{
		'{20,   24'h000011, 12'h001, 1'b0, 1'b1, 7'd1,   0},
		'{60,   24'h000012, 12'h001, 1'b1, 1'b0, 7'd5,   0},    // Unmatched
		'{100,  24'h000013, 12'h002, 1'b1, 1'b1, 7'd10,  0},
		'{104,  24'h000014, 12'h003, 1'b0, 1'b1, 7'd127, 0},    // Close behind previous
		'{400,  24'h000015, 12'h004, 1'b1, 1'b1, 7'd0,   0},    // Header only
		'{500,  24'h000016, 12'h005, 1'b0, 1'b1, 7'd3,   40},
		'{4090, 24'h000017, 12'h006, 1'b1, 1'b1, 7'd16,  0},    // Crosses ring end
		'{4300, 24'h000018, 12'h007, 1'b0, 1'b1, 7'd8,   3400}  // Near overflow
	};

	logic       CLK;
	logic       RST_RESYNC;
	logic       wren_i;
	wdata_t     wdata_i;
	ovlp_cnt_t  ovlp_cnt_i;
	logic       ovlp_i;
	logic       multi_ovlp_i;
	logic       l1a_wrt_en_i;
	logic       l1a_match_i;
	logic       l1a_phase_i;
	l1a_cnt_t   l1a_cnt_i;
	match_cnt_t l1a_match_cnt_i;
	logic       evt_buf_afl_i;
	samp_max_t  samp_max_i;
	l1a_cnt_t   evt_l1a_cnt_o;
	match_cnt_t evt_match_cnt_o;
	logic       evt_phase_o;
	logic       evt_push_o;
	sample_t    rdata_o;
	logic       data_push_o;
	logic       warn_o;

	sample_t model_mem [ring_depth_c];
	hdr_t    exp_hdr [$];
	int      exp_data [$]; // Absolute sample indices still due
	int      wr_count   = 0;
	int      errors     = 0;
	int      checks     = 0;
	int      n_match    = 0;
	int      done_cnt   = 0;
	int      warn_mode  = 0; // 0 low, 1 tracked, 2 not checked
	int      warn_start = 0;
	int      warn_row   = -1;
	logic    warn_seen  = 1'b0;

	ringbuf i_ringbuf (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_error(input string what);
		$display("[ERROR] %0t %s", $time, what);
		errors++;
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] %0t %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic close_event(input hdr_t h);
		$display("Test %0d done: header and %0d words checked, %0d errors so far",
			h.row, h.smax, errors);
		done_cnt++;
		if (h.row == warn_row)
			warn_mode = 0;
	endtask

	initial begin
		CLK = 1'b0;
		forever #(clk_period_c / 2) CLK = ~CLK;
	end

	// One sample per cycle once reset is released
	initial begin : sample_writer
		logic [31:0] lcg_st;
		sample_t     smp;
		lcg_st = 32'h7898;
		@(negedge RST_RESYNC);
		forever begin
			@(negedge CLK);
			lcg_st = lcg_next(lcg_st);
			smp = {lcg_st[31], lcg_st[30], lcg_st[29:26], wr_count[11:0]};
			model_mem[wr_count % ring_depth_c] = smp;
			wren_i       = 1'b1;
			wdata_i      = smp[11:0];
			ovlp_cnt_i   = smp[15:12];
			ovlp_i       = smp[16];
			multi_ovlp_i = smp[17];
			samp_max_i   = (exp_hdr.size() != 0) ? exp_hdr[0].smax : '0; // Next event length
			wr_count++;
		end
	end

	initial begin : monitor
		hdr_t cur;
		int   idx;
		logic afl_q;
		logic warn_exp;
		afl_q = 1'b0;
		cur   = '0;
		@(negedge RST_RESYNC);
		forever begin
			@(posedge CLK);
			assert (!(evt_push_o && afl_q))
				else report_error("header pushed while evt_buf_afl_i was high");
			afl_q = evt_buf_afl_i;
			if (evt_push_o) begin
				assert (exp_hdr.size() != 0)
					else report_error("header pushed with no matched L1A queued");
				if (exp_hdr.size() != 0) begin
					cur = exp_hdr.pop_front();
					check_val("evt_l1a_cnt_o", 32'(evt_l1a_cnt_o), 32'(cur.l1a_cnt));
					check_val("evt_match_cnt_o", 32'(evt_match_cnt_o), 32'(cur.match_cnt));
					check_val("evt_phase_o", 32'(evt_phase_o), 32'(cur.phase));
					for (int k = 0; k < int'(cur.smax); k++)
						exp_data.push_back(cur.start + k);
					if (cur.smax == '0)
						close_event(cur);
				end
			end
			if (data_push_o) begin
				assert (exp_data.size() != 0)
					else report_error("data pushed with no word outstanding");
				if (exp_data.size() != 0) begin
					idx = exp_data.pop_front();
					check_val("rdata_o", 32'(rdata_o), 32'(model_mem[idx % ring_depth_c]));
					if (exp_data.size() == 0)
						close_event(cur);
				end
			end
			if (warn_mode == 1) begin
				warn_exp  = ((wr_count - 1 - warn_start) % ring_depth_c) > warn_fill_c;
				warn_seen = warn_seen | warn_o;
			end else begin
				warn_exp = 1'b0;
			end
			if (warn_mode != 2)
				check_val("warn_o", 32'(warn_o), 32'(warn_exp));
		end
	end

	initial begin : stimulus
		hdr_t h;
		RST_RESYNC      = 1'b1;
		wren_i          = 1'b0;
		wdata_i         = '0;
		ovlp_cnt_i      = '0;
		ovlp_i          = 1'b0;
		multi_ovlp_i    = 1'b0;
		l1a_wrt_en_i    = 1'b0;
		l1a_match_i     = 1'b0;
		l1a_phase_i     = 1'b0;
		l1a_cnt_i       = '0;
		l1a_match_cnt_i = '0;
		evt_buf_afl_i   = 1'b0;
		samp_max_i      = '0;
		repeat (4) @(negedge CLK);
		RST_RESYNC = 1'b0;
		@(posedge CLK);
		check_val("evt_push_o", 32'(evt_push_o), 32'd0);
		check_val("data_push_o", 32'(data_push_o), 32'd0);
		check_val("warn_o", 32'(warn_o), 32'd0);
		for (int r = 0; r < n_rows_c; r++) begin
			do @(posedge CLK); while (wr_count != tbl[r].trig);
			if (tbl[r].match) begin
				h = '{row: r, start: tbl[r].trig, l1a_cnt: tbl[r].cnt,
					match_cnt: tbl[r].mcnt, phase: tbl[r].phase, smax: tbl[r].smax};
				exp_hdr.push_back(h);
				n_match++;
			end
			@(negedge CLK); // Lands on sample tbl[r].trig
			l1a_wrt_en_i    = 1'b1;
			l1a_match_i     = tbl[r].match;
			l1a_phase_i     = tbl[r].phase;
			l1a_cnt_i       = tbl[r].cnt;
			l1a_match_cnt_i = tbl[r].mcnt;
			if (tbl[r].hold > 0)
				evt_buf_afl_i = 1'b1;
			if (tbl[r].hold > warn_fill_c) begin
				warn_start = tbl[r].trig;
				warn_row   = r;
				warn_mode  = 1;
			end
			@(negedge CLK);
			l1a_wrt_en_i = 1'b0;
			l1a_match_i  = 1'b0;
			if (tbl[r].hold > 0) begin
				repeat (tbl[r].hold - 1) @(negedge CLK);
				evt_buf_afl_i = 1'b0;
				if (warn_mode == 1) begin
					assert (warn_seen) else report_error("warn_o never rose during the hold");
					warn_mode = 2;
				end
			end
			if (!tbl[r].match)
				$display("Test %0d done: unmatched L1A, no header expected", r);
		end
		while (done_cnt != n_match) @(posedge CLK);
		repeat (10) @(posedge CLK);
		$display("Tests %0d, checks %0d, errors %0d", n_rows_c, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin : watchdog
		int limit;
		limit = 1000 + tbl[n_rows_c-1].trig; // Margin plus last trigger
		for (int r = 0; r < n_rows_c; r++)
			limit += tbl[r].hold + 2 * int'(tbl[r].smax) + 20;
		#(limit * clk_period_c);
		$display("Watchdog expired after %0d cycles, readout did not complete", limit);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- logic/ringbuf.sv
`timescale 1ns/1ps

module ringbuf
	import ring_pkg::*;
(
	input  logic       CLK,
	input  logic       RST_RESYNC,
	input  logic       wren_i,
	input  wdata_t     wdata_i,
	input  ovlp_cnt_t  ovlp_cnt_i,
	input  logic       ovlp_i,
	input  logic       multi_ovlp_i,
	input  logic       l1a_wrt_en_i,
	input  logic       l1a_match_i,
	input  logic       l1a_phase_i,
	input  l1a_cnt_t   l1a_cnt_i,
	input  match_cnt_t l1a_match_cnt_i,
	input  logic       evt_buf_afl_i,
	input  samp_max_t  samp_max_i,
	output l1a_cnt_t   evt_l1a_cnt_o,
	output match_cnt_t evt_match_cnt_o,
	output logic       evt_phase_o,
	output logic       evt_push_o,
	output sample_t    rdata_o,
	output logic       data_push_o,
	output logic       warn_o
);

	sample_t    wsample;
	logic       l1a_push;
	ring_addr_t waddr;
	ring_addr_t raddr;
	ring_addr_t head_start_addr;
	logic       fifo_not_empty;
	logic       ring_amt;
	logic       ld_addr;
	logic       nxt_wrd;
	logic       nxt_l1a;

	assign wsample    = {multi_ovlp_i, ovlp_i, ovlp_cnt_i, wdata_i};
	assign l1a_push   = l1a_wrt_en_i && l1a_match_i; // Matched triggers only
	assign evt_push_o = ld_addr;

	l1a_fifo i_l1a_fifo (
		.CLK          (CLK),
		.RST_RESYNC   (RST_RESYNC),
		.push_i       (l1a_push),
		.pop_i        (nxt_l1a),
		.l1a_cnt_i    (l1a_cnt_i),
		.match_cnt_i  (l1a_match_cnt_i),
		.phase_i      (l1a_phase_i),
		.start_addr_i (waddr), // Event starts at current write slot
		.l1a_cnt_o    (evt_l1a_cnt_o),
		.match_cnt_o  (evt_match_cnt_o),
		.phase_o      (evt_phase_o),
		.start_addr_o (head_start_addr),
		.not_empty_o  (fifo_not_empty)
	);

	sample_ram i_sample_ram (
		.CLK        (CLK),
		.RST_RESYNC (RST_RESYNC),
		.we_i       (wren_i),
		.waddr_i    (waddr),
		.wdata_i    (wsample),
		.rd_en_i    (nxt_wrd),
		.raddr_i    (raddr),
		.rdata_o    (rdata_o),
		.rvalid_o   (data_push_o)
	);

	ring_addr_ctrl i_ring_addr_ctrl (
		.CLK              (CLK),
		.RST_RESYNC       (RST_RESYNC),
		.wren_i           (wren_i),
		.ld_addr_i        (ld_addr),
		.nxt_wrd_i        (nxt_wrd),
		.start_addr_i     (head_start_addr),
		.fifo_not_empty_i (fifo_not_empty),
		.waddr_o          (waddr),
		.raddr_o          (raddr),
		.ring_amt_o       (ring_amt),
		.warn_o           (warn_o)
	);

	readout_fsm i_readout_fsm (
		.CLK              (CLK),
		.RST_RESYNC       (RST_RESYNC),
		.fifo_not_empty_i (fifo_not_empty),
		.evt_buf_afl_i    (evt_buf_afl_i),
		.ring_amt_i       (ring_amt),
		.samp_max_i       (samp_max_i),
		.ld_addr_o        (ld_addr),
		.nxt_wrd_o        (nxt_wrd),
		.nxt_l1a_o        (nxt_l1a)
	);

endmodule

//--- logic/readout_fsm.sv
`timescale 1ns/1ps

module readout_fsm
	import ring_pkg::*;
	import readout_pkg::*;
(
	input  logic      CLK,
	input  logic      RST_RESYNC,
	input  logic      fifo_not_empty_i,
	input  logic      evt_buf_afl_i,
	input  logic      ring_amt_i,
	input  samp_max_t samp_max_i,
	output logic      ld_addr_o,
	output logic      nxt_wrd_o,
	output logic      nxt_l1a_o
);

	readout_state_t state_q;
	readout_state_t state_d;
	samp_max_t      wrd_cnt; // Words still to issue
	logic           evt_start;

	assign evt_start = (state_q == st_idle) && fifo_not_empty_i && !evt_buf_afl_i;

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			state_q <= st_idle;
			wrd_cnt <= '0;
		end else begin
			state_q <= state_d;
			if (evt_start)
				wrd_cnt <= samp_max_i; // Event length fixed at start
			else if (nxt_wrd_o)
				wrd_cnt <= wrd_cnt - 1'b1;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (evt_start)
					state_d = st_load;
			end
			st_load: begin
				if (wrd_cnt == wrd_none_c)
					state_d = st_pop; // Header only
				else
					state_d = st_read;
			end
			st_read: begin
				if (nxt_wrd_o && (wrd_cnt == wrd_last_c))
					state_d = st_pop;
			end
			st_pop: begin
				state_d = st_idle;
			end
			default: begin
				state_d = st_idle;
			end
		endcase
	end

	// Read is only entered with words left, so the strobe
	// waits on the ring alone
	assign ld_addr_o = (state_q == st_load);
	assign nxt_wrd_o = (state_q == st_read) && !ring_amt_i;
	assign nxt_l1a_o = (state_q == st_pop);

endmodule

//--- logic/ring_addr_ctrl.sv
`timescale 1ns/1ps

module ring_addr_ctrl
	import ring_pkg::*;
(
	input  logic       CLK,
	input  logic       RST_RESYNC,
	input  logic       wren_i,
	input  logic       ld_addr_i,
	input  logic       nxt_wrd_i,
	input  ring_addr_t start_addr_i,
	input  logic       fifo_not_empty_i,
	output ring_addr_t waddr_o,
	output ring_addr_t raddr_o,
	output logic       ring_amt_o,
	output logic       warn_o
);

	ring_ptr_t  wr_ptr;
	ring_addr_t rd_addr;
	ring_addr_t rd_fill;
	ring_addr_t st_fill;

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_ptr <= '0;
		end else if (wren_i) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// Read address follows the event being read out
	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			rd_addr <= '0;
		end else if (ld_addr_i) begin
			rd_addr <= start_addr_i;
		end else if (nxt_wrd_i) begin
			rd_addr <= rd_addr + 1'b1; // Wraps at ring end
		end
	end

	assign waddr_o = ring_addr_t'(wr_ptr);
	assign raddr_o = rd_addr;

	// Distances modulo ring length
	assign rd_fill = ring_addr_t'(wr_ptr - ring_ptr_t'(rd_addr));
	assign st_fill = ring_addr_t'(wr_ptr - ring_ptr_t'(start_addr_i));

	// Reader too close to writer
	assign ring_amt_o = (rd_fill < ring_amt_c);

	// Oldest queued event about to be overwritten
	assign warn_o = fifo_not_empty_i && (st_fill > warn_fill_c);

endmodule

//--- logic/sample_ram.sv
`timescale 1ns/1ps

module sample_ram
	import ring_pkg::*;
(
	input  logic       CLK,
	input  logic       RST_RESYNC,
	input  logic       we_i,
	input  ring_addr_t waddr_i,
	input  sample_t    wdata_i,
	input  logic       rd_en_i,
	input  ring_addr_t raddr_i,
	output sample_t    rdata_o,
	output logic       rvalid_o
);

	sample_t    mem [ring_depth_c];
	ring_addr_t raddr_q;
	logic       rd_v1;

	always_ff @(posedge CLK) begin
		if (we_i)
			mem[waddr_i] <= wdata_i;
	end

	// Stage 1 address, stage 2 data
	always_ff @(posedge CLK) begin
		if (rd_en_i)
			raddr_q <= raddr_i;
		if (rd_v1)
			rdata_o <= mem[raddr_q];
	end

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			rd_v1    <= 1'b0;
			rvalid_o <= 1'b0;
		end else begin
			rd_v1    <= rd_en_i;
			rvalid_o <= rd_v1;
		end
	end

endmodule

//--- logic/l1a_fifo.sv
`timescale 1ns/1ps

module l1a_fifo
	import ring_pkg::*;
(
	input  logic       CLK,
	input  logic       RST_RESYNC,
	input  logic       push_i,
	input  logic       pop_i,
	input  l1a_cnt_t   l1a_cnt_i,
	input  match_cnt_t match_cnt_i,
	input  logic       phase_i,
	input  ring_addr_t start_addr_i,
	output l1a_cnt_t   l1a_cnt_o,
	output match_cnt_t match_cnt_o,
	output logic       phase_o,
	output ring_addr_t start_addr_o,
	output logic       not_empty_o
);

	l1a_cnt_t   cnt_mem   [l1a_depth_c];
	match_cnt_t match_mem [l1a_depth_c];
	logic       phase_mem [l1a_depth_c];
	ring_addr_t addr_mem  [l1a_depth_c];

	l1a_idx_t wr_idx;
	l1a_idx_t rd_idx;
	l1a_lvl_t lvl;
	logic     full;
	logic     push_ok;
	logic     pop_ok;

	assign full        = (lvl == l1a_depth_c);
	assign not_empty_o = (lvl != '0);
	assign push_ok     = push_i && !full; // Lost when full
	assign pop_ok      = pop_i && not_empty_o;

	always_ff @(posedge CLK) begin
		if (push_ok) begin
			cnt_mem[wr_idx]   <= l1a_cnt_i;
			match_mem[wr_idx] <= match_cnt_i;
			phase_mem[wr_idx] <= phase_i;
			addr_mem[wr_idx]  <= start_addr_i;
		end
	end

	always_ff @(posedge CLK or posedge RST_RESYNC) begin
		if (RST_RESYNC) begin
			wr_idx <= '0;
			rd_idx <= '0;
			lvl    <= '0;
		end else begin
			if (push_ok)
				wr_idx <= wr_idx + 1'b1;
			if (pop_ok)
				rd_idx <= rd_idx + 1'b1;
			case ({push_ok, pop_ok})
				2'b10:   lvl <= lvl + 1'b1;
				2'b01:   lvl <= lvl - 1'b1;
				default: lvl <= lvl;
			endcase
		end
	end

	// Head is always visible
	assign l1a_cnt_o    = cnt_mem[rd_idx];
	assign match_cnt_o  = match_mem[rd_idx];
	assign phase_o      = phase_mem[rd_idx];
	assign start_addr_o = addr_mem[rd_idx];

endmodule

//--- logic/readout_pkg.sv
package readout_pkg;

	import ring_pkg::*;

	// Readout sequencer states
	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_read,
		st_pop
	} readout_state_t;

	// Word counter values seen by the sequencer
	localparam samp_max_t wrd_none_c = 7'd0; // Event without data
	localparam samp_max_t wrd_last_c = 7'd1; // Final read strobe of an event

endpackage

//--- logic/ring_pkg.sv
package ring_pkg;

	localparam int unsigned ring_depth_c = 4096;

	typedef logic [$clog2(ring_depth_c)-1:0] ring_addr_t;
	typedef logic [$clog2(ring_depth_c):0]   ring_ptr_t; // MSB toggles on each wrap

	typedef logic [11:0] wdata_t;
	typedef logic [3:0]  ovlp_cnt_t;
	typedef logic [17:0] sample_t; // {multi_ovlp, ovlp, ovlp_cnt, data}

	typedef logic [23:0] l1a_cnt_t;
	typedef logic [11:0] match_cnt_t;
	typedef logic [6:0]  samp_max_t;

	typedef logic [4:0] l1a_lvl_t;

	localparam l1a_lvl_t l1a_depth_c = 5'd16;

	typedef logic [$clog2(l1a_depth_c)-1:0] l1a_idx_t;

	// Fill thresholds, in samples
	localparam ring_addr_t warn_fill_c = 12'd3328;
	localparam ring_addr_t ring_amt_c  = 12'd7;

endpackage
